//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	parameter int pc_width = 10; // byte address width of the PC

	// major opcodes
	localparam logic [5:0] OP_TY_B = 6'h24;
	localparam logic [5:0] OP_TY_J = 6'h28;
	localparam logic [5:0] OP_JREG = 6'h2c;

	localparam logic SUB_BEQ = 1'b0; // sub_op_b values
	localparam logic SUB_BNE = 1'b1;
	localparam logic SUB_JJ  = 1'b0; // sub_op_j values
	localparam logic SUB_JAL = 1'b1;

	// conditional branch format, rt and ra go to the comparator
	typedef struct packed {
		logic        reserved;
		logic [5:0]  opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic        sub_op_b;
		logic [13:0] imm14;
	} b_fmt_t;

	typedef struct packed {
		logic        reserved;
		logic [5:0]  opcode; // same bit position as in b_fmt_t
		logic        sub_op_j;
		logic [23:0] imm24;
	} j_fmt_t;

	typedef union packed {
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} instr_t;

	// source of the next PC
	typedef enum logic [1:0] {
		PC_4        = 2'd0,
		PC_14BIT    = 2'd1,
		PC_24BIT    = 2'd2,
		PC_REGISTER = 2'd3
	} pc_sel_e;

	typedef struct packed {
		logic                valid; // 0 marks a bubble
		logic [pc_width-1:0] pc;
		instr_t              instr;
	} decode_t;

endpackage

`default_nettype wire

//--- pc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module pc_counter #(
	parameter int PC_WIDTH = 10
) (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                enable_pc,
	input  wire logic                do_hazard,
	input  wire cpu_pkg::pc_sel_e    pc_sel,
	input  wire cpu_pkg::instr_t     instr,
	input  wire logic [31:0]         reg_rb_data,
	output logic      [PC_WIDTH-1:0] current_pc
);
	import cpu_pkg::*;

	logic [PC_WIDTH-1:0] pc_plus4;
	logic [PC_WIDTH-1:0] pc_base;
	logic [PC_WIDTH-1:0] off14;
	logic [PC_WIDTH-1:0] off24;
	logic [PC_WIDTH-1:0] target_reg;
	logic [PC_WIDTH-1:0] next_pc;

	assign pc_plus4 = current_pc + PC_WIDTH'(4);
	assign pc_base  = current_pc - PC_WIDTH'(4); // pc of the instruction sitting in decode

	// sign bit, low eight bits, then a zero bit
	assign off14 = {{(PC_WIDTH-9){instr.b_fmt.imm14[13]}}, instr.b_fmt.imm14[7:0], 1'b0};
	assign off24 = {{(PC_WIDTH-9){instr.j_fmt.imm24[23]}}, instr.j_fmt.imm24[7:0], 1'b0};

	assign target_reg = reg_rb_data[PC_WIDTH-1:0];

	always_comb begin
		case (pc_sel)
			PC_14BIT:    next_pc = pc_base + off14;
			PC_24BIT:    next_pc = pc_base + off24;
			PC_REGISTER: next_pc = target_reg;
			default:     next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			current_pc <= '0;
		end else if (enable_pc && !do_hazard) begin // hazard freezes the fetch
			current_pc <= next_pc;
		end
	end

	// branch offsets and rb values are expected to keep the PC word aligned
	a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
		current_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- branch_control.sv
`timescale 1ns/1ps
`default_nettype none

module branch_control (
	input  wire cpu_pkg::decode_t decode,
	input  wire logic             reg_rt_ra_equal,
	output cpu_pkg::pc_sel_e      pc_sel,
	output logic                  do_jump_link,
	output logic                  do_flush_reg1
);
	import cpu_pkg::*;

	logic [5:0] opcode;
	logic       sub_op_b;
	logic       sub_op_j;
	logic       branch_taken;

	// the same word seen as branch or jump format
	assign opcode   = decode.instr.b_fmt.opcode;
	assign sub_op_b = decode.instr.b_fmt.sub_op_b;
	assign sub_op_j = decode.instr.j_fmt.sub_op_j;

	always_comb begin
		case (sub_op_b)
			SUB_BEQ: branch_taken = reg_rt_ra_equal;
			SUB_BNE: branch_taken = !reg_rt_ra_equal;
			default: branch_taken = 1'b0;
		endcase
	end

	always_comb begin
		pc_sel       = PC_4;
		do_jump_link = 1'b0;
		if (decode.valid) begin // a bubble never redirects
			case (opcode)
				OP_TY_B: begin
					if (branch_taken) begin
						pc_sel = PC_14BIT;
					end
				end
				OP_TY_J: begin
					pc_sel = PC_24BIT;
					case (sub_op_j)
						SUB_JJ:  do_jump_link = 1'b0;
						SUB_JAL: do_jump_link = 1'b1; // link register write happens downstream
						default: do_jump_link = 1'b0;
					endcase
				end
				OP_JREG: pc_sel = PC_REGISTER;
				default: pc_sel = PC_4;
			endcase
		end
	end

	// any redirect kills the instruction fetched behind it
	assign do_flush_reg1 = (pc_sel != PC_4);

	always_comb begin
		a_link_is_jump: assert (!do_jump_link || pc_sel == PC_24BIT);
	end

endmodule

`default_nettype wire

//--- instr_rom.sv
`timescale 1ns/1ps
`default_nettype none

module instr_rom #(
	parameter int PC_WIDTH = 10
) (
	input  wire logic [PC_WIDTH-1:0] current_pc,
	output cpu_pkg::instr_t          fetch_instr
);

	localparam int depth = 2 ** (PC_WIDTH - 2);

	logic [31:0] rom [depth];

	initial begin
		$readmemh("program.hex", rom);
	end

	// word addressed, the two byte offset bits are dropped
	assign fetch_instr = rom[current_pc[PC_WIDTH-1:2]];

endmodule

`default_nettype wire

//--- if_id_reg.sv
`timescale 1ns/1ps
`default_nettype none

module if_id_reg #(
	parameter int PC_WIDTH = 10
) (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                enable_pc,
	input  wire logic                do_hazard,
	input  wire logic                do_flush_reg1,
	input  wire logic [PC_WIDTH-1:0] current_pc,
	input  wire cpu_pkg::instr_t     fetch_instr,
	output cpu_pkg::decode_t         decode
);
	import cpu_pkg::*;

	logic                valid_q;
	logic [PC_WIDTH-1:0] pc_q;
	instr_t              instr_q;
	logic                load;

	assign load = enable_pc && !do_hazard; // same advance condition as the PC

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (load) begin
			valid_q <= !do_flush_reg1; // flush turns the slot into a bubble
		end
	end

	// payload follows the fetch even into a bubble, only valid matters then
	always_ff @(posedge clock) begin
		if (load) begin
			pc_q    <= current_pc;
			instr_q <= fetch_instr;
		end
	end

	assign decode = '{valid: valid_q, pc: pc_q, instr: instr_q};

	a_flush_bubble: assert property (@(posedge clock) disable iff (reset)
		(do_flush_reg1 && load) |=> !decode.valid);

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter int PC_WIDTH = cpu_pkg::pc_width
) (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                enable_pc,
	input  wire logic                do_hazard,
	input  wire logic                reg_rt_ra_equal,
	input  wire logic [31:0]         reg_rb_data,
	output logic      [PC_WIDTH-1:0] current_pc,
	output cpu_pkg::decode_t         decode,
	output logic                     do_jump_link,
	output logic                     do_flush_reg1
);
	import cpu_pkg::*;

	pc_sel_e pc_sel;
	instr_t  fetch_instr;

	pc_counter #(.PC_WIDTH(PC_WIDTH)) pc_counter_i (
		.clock       (clock),
		.reset       (reset),
		.enable_pc   (enable_pc),
		.do_hazard   (do_hazard),
		.pc_sel      (pc_sel),
		.instr       (decode.instr), // immediates come from the decode slot
		.reg_rb_data (reg_rb_data),
		.current_pc  (current_pc)
	);

	branch_control branch_control_i (
		.decode          (decode),
		.reg_rt_ra_equal (reg_rt_ra_equal),
		.pc_sel          (pc_sel),
		.do_jump_link    (do_jump_link),
		.do_flush_reg1   (do_flush_reg1)
	);

	instr_rom #(.PC_WIDTH(PC_WIDTH)) instr_rom_i (
		.current_pc  (current_pc),
		.fetch_instr (fetch_instr)
	);

	if_id_reg #(.PC_WIDTH(PC_WIDTH)) if_id_reg_i (
		.clock         (clock),
		.reset         (reset),
		.enable_pc     (enable_pc),
		.do_hazard     (do_hazard),
		.do_flush_reg1 (do_flush_reg1),
		.current_pc    (current_pc),
		.fetch_instr   (fetch_instr),
		.decode        (decode)
	);

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 4
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clock = ~clock; // first rising edge at half a period
		end
	end

endmodule

`default_nettype wire

//--- tb_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;
	import cpu_pkg::*;

	localparam int rom_words      = 2 ** (pc_width - 2);
	localparam int reset_cycles   = 4;
	localparam int walk_limit     = 24; // longest walk from reset to a decode slot is 21
	localparam int test_runs      = 9; // restarts over the whole run
	localparam int timeout_cycles = 2 * test_runs * (reset_cycles + walk_limit);

	// program landmarks, each taken redirect lands on the next one
	localparam logic [pc_width-1:0] last_fill_pc = pc_width'(32'h014);
	localparam logic [pc_width-1:0] beq_pc       = pc_width'(32'h018);
	localparam logic [pc_width-1:0] bne_pc       = pc_width'(32'h038);
	localparam logic [pc_width-1:0] j_pc         = pc_width'(32'h048);
	localparam logic [pc_width-1:0] jal_pc       = pc_width'(32'h058);
	localparam logic [pc_width-1:0] jr_pc        = pc_width'(32'h068);

	typedef struct packed {
		logic                redirect;
		logic                link;
		logic [pc_width-1:0] target;
	} verdict_t;

	logic                clock;
	logic                reset;
	logic                enable_pc;
	logic                do_hazard;
	logic                reg_rt_ra_equal;
	logic [31:0]         reg_rb_data;
	logic [pc_width-1:0] current_pc;
	decode_t             decode;
	logic                do_jump_link;
	logic                do_flush_reg1;

	logic        nxt_reset; // applied at the next rising edge
	logic        nxt_enable;
	logic        nxt_hazard;
	logic        nxt_equal;
	logic [31:0] nxt_rb;

	logic [31:0]         rom_image [rom_words];
	logic [pc_width-1:0] exp_pc;
	decode_t             exp_decode;
	int                  pc_errors;
	int                  decode_errors;
	int                  flag_errors;
	int                  other_errors;
	int                  cycle_count;

	tb_clock #(.PERIOD_NS(4)) clock_i (.clock(clock));

	fetch_unit #(.PC_WIDTH(pc_width)) dut_i (
		.clock           (clock),
		.reset           (reset),
		.enable_pc       (enable_pc),
		.do_hazard       (do_hazard),
		.reg_rt_ra_equal (reg_rt_ra_equal),
		.reg_rb_data     (reg_rb_data),
		.current_pc      (current_pc),
		.decode          (decode),
		.do_jump_link    (do_jump_link),
		.do_flush_reg1   (do_flush_reg1)
	);

	// sign bit weighs -512, the eight low bits are shifted up by one
	function automatic int rel_offset(input logic sign, input logic [7:0] low);
		int off;
		off = 2 * int'(low);
		if (sign) begin
			off = off - 512;
		end
		return off;
	endfunction

	function automatic verdict_t decide(input decode_t slot, input logic equal,
			input logic [31:0] rb);
		verdict_t    v;
		logic [31:0] word;
		logic [5:0]  op;
		logic        taken;
		v = '0;
		word = slot.instr;
		op = word[30:25];
		if (slot.valid && op == OP_TY_B) begin
			taken = (word[14] == SUB_BNE) ? !equal : equal;
			v.redirect = taken;
			v.target = pc_width'(int'(slot.pc) + rel_offset(word[13], word[7:0]));
		end else if (slot.valid && op == OP_TY_J) begin
			v.redirect = 1'b1;
			v.link = (word[24] == SUB_JAL);
			v.target = pc_width'(int'(slot.pc) + rel_offset(word[23], word[7:0]));
		end else if (slot.valid && op == OP_JREG) begin
			v.redirect = 1'b1;
			v.target = rb[pc_width-1:0];
		end
		return v;
	endfunction

	task automatic check_pc(input logic [pc_width-1:0] got, input logic [pc_width-1:0] want);
		if (got !== want) begin
			pc_errors++;
			$display("FAIL current_pc got %h expected %h at %0t", got, want, $time);
		end
	endtask

	task automatic check_decode(input decode_t got, input decode_t want);
		if (got.valid !== want.valid
				|| (want.valid && (got.pc !== want.pc || got.instr !== want.instr))) begin
			decode_errors++;
			$display("FAIL decode got valid %h pc %h instr %h expected valid %h pc %h instr %h",
				got.valid, got.pc, got.instr, want.valid, want.pc, want.instr);
		end
	endtask

	task automatic check_flags(input logic link_got, input logic flush_got,
			input logic link_want, input logic flush_want);
		if (link_got !== link_want || flush_got !== flush_want) begin
			flag_errors++;
			$display("FAIL do_jump_link/do_flush_reg1 got %h/%h expected %h/%h at %0t",
				link_got, flush_got, link_want, flush_want, $time);
		end
	endtask

	// one clock of the reference model, then a full compare at the falling edge
	task automatic step();
		verdict_t            v;
		logic [pc_width-1:0] next_pc;
		decode_t             next_slot;
		v = decide(exp_decode, reg_rt_ra_equal, reg_rb_data);
		next_pc = exp_pc;
		next_slot = exp_decode;
		if (reset) begin
			next_pc = '0;
			next_slot.valid = 1'b0;
		end else if (enable_pc && !do_hazard) begin
			next_pc = v.redirect ? v.target : exp_pc + pc_width'(4);
			next_slot.valid = !v.redirect;
			next_slot.pc = exp_pc;
			next_slot.instr = rom_image[exp_pc[pc_width-1:2]];
		end
		@(posedge clock);
		reset <= nxt_reset;
		enable_pc <= nxt_enable;
		do_hazard <= nxt_hazard;
		reg_rt_ra_equal <= nxt_equal;
		reg_rb_data <= nxt_rb;
		exp_pc = next_pc;
		exp_decode = next_slot;
		@(negedge clock);
		v = decide(exp_decode, reg_rt_ra_equal, reg_rb_data);
		check_pc(current_pc, exp_pc);
		check_decode(decode, exp_decode);
		check_flags(do_jump_link, do_flush_reg1, v.link, v.redirect);
	endtask

	task automatic restart(input logic equal);
		nxt_reset = 1'b1;
		nxt_enable = 1'b1;
		nxt_hazard = 1'b0;
		nxt_equal = equal;
		repeat (reset_cycles) step();
		nxt_reset = 1'b0;
		step();
	endtask

	task automatic run_to(input logic [pc_width-1:0] pc);
		int n;
		n = 0;
		while (!(exp_decode.valid && exp_decode.pc == pc) && n < walk_limit) begin
			step();
			n++;
		end
		if (!(exp_decode.valid && exp_decode.pc == pc)) begin
			other_errors++;
			$display("instruction at pc %h never reached the decode slot", pc);
		end
	endtask

	task automatic expect_redirect(input logic [pc_width-1:0] target);
		decode_t bubble;
		bubble = '0;
		check_pc(current_pc, target);
		check_decode(decode, bubble);
	endtask

	task automatic test_sequential();
		logic [pc_width-1:0] prev;
		decode_t             want;
		restart(1'b0);
		prev = '0; // fetch starts again at address 0
		repeat (5) begin
			step();
			want.valid = 1'b1;
			want.pc = prev;
			want.instr = rom_image[prev[pc_width-1:2]];
			check_pc(current_pc, prev + pc_width'(4));
			check_decode(decode, want);
			check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b0);
			prev = prev + pc_width'(4);
		end
	endtask

	task automatic test_branches();
		restart(1'b1); // BEQ taken, BNE falls through
		run_to(beq_pc);
		check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b1);
		step();
		expect_redirect(bne_pc);
		step();
		check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b0);
		step();
		check_pc(current_pc, bne_pc + pc_width'(8));
		restart(1'b0); // BEQ falls through, BNE taken
		run_to(beq_pc);
		check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b0);
		run_to(bne_pc);
		check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b1);
		step();
		expect_redirect(j_pc);
	endtask

	task automatic test_jumps();
		restart(1'b0);
		run_to(j_pc);
		check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b1);
		step();
		expect_redirect(jal_pc);
		step();
		check_flags(do_jump_link, do_flush_reg1, 1'b1, 1'b1);
		step();
		expect_redirect(jr_pc);
	endtask

	task automatic test_jump_register();
		logic [31:0] rb;
		repeat (2) begin
			// upper bits random, the target lands in the filler block at 0x080
			rb = ($urandom() & 32'hffff_fc00) | (32'h080 + (($urandom() % 8) << 2));
			nxt_rb = rb;
			restart(1'b0);
			run_to(jr_pc);
			check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b1);
			step();
			expect_redirect(rb[pc_width-1:0]);
			repeat (12) step(); // runs through the backward jump to address 0
		end
	endtask

	task automatic test_stall();
		decode_t want;
		int      i;
		want.valid = 1'b1;
		want.pc = beq_pc;
		want.instr = rom_image[beq_pc[pc_width-1:2]];
		restart(1'b1);
		run_to(last_fill_pc);
		nxt_hazard = 1'b1;
		step(); // the taken BEQ enters decode as the hazard rises
		for (i = 0; i < 8; i++) begin
			if (i == 4) begin
				nxt_hazard = 1'b0;
				nxt_enable = 1'b0;
			end
			step();
			check_pc(current_pc, beq_pc + pc_width'(4));
			check_decode(decode, want);
			check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b1);
		end
		nxt_enable = 1'b1;
		step();
		check_pc(current_pc, beq_pc + pc_width'(4));
		step();
		expect_redirect(bne_pc);
	endtask

	task automatic test_reset();
		decode_t want;
		restart(1'b1);
		run_to(last_fill_pc);
		nxt_reset = 1'b1; // reset hits while a redirect is pending
		repeat (reset_cycles) step();
		want = '0;
		check_pc(current_pc, '0);
		check_decode(decode, want);
		check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b0);
		nxt_reset = 1'b0;
		step();
		check_pc(current_pc, '0);
		step();
		want.valid = 1'b1;
		want.instr = rom_image[0];
		check_pc(current_pc, pc_width'(4));
		check_decode(decode, want);
	endtask

	task automatic report_counts();
		$display("errors: current_pc %0d, decode %0d, flags %0d, other %0d",
			pc_errors, decode_errors, flag_errors, other_errors);
	endtask

	initial begin
		void'($urandom(32'h7b1c_3332));
		$readmemh("program.hex", rom_image);
		reset = 1'b1;
		enable_pc = 1'b1;
		do_hazard = 1'b0;
		reg_rt_ra_equal = 1'b0;
		reg_rb_data = '0;
		nxt_reset = 1'b0;
		nxt_enable = 1'b1;
		nxt_hazard = 1'b0;
		nxt_equal = 1'b0;
		nxt_rb = '0;
		exp_pc = '0;
		exp_decode = '0;
		pc_errors = 0;
		decode_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		repeat (reset_cycles - 1) @(posedge clock);
		step();
		check_pc(current_pc, '0);
		check_flags(do_jump_link, do_flush_reg1, 1'b0, 1'b0);
		test_sequential();
		test_branches();
		test_jumps();
		test_jump_register();
		test_stall();
		test_reset();
		report_counts();
		if (pc_errors + decode_errors + flag_errors + other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout, the run did not finish within %0d clock cycles", timeout_cycles);
		report_counts();
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- program.hex
// one 32-bit instruction word per column, word address 0 first
// opcode 6 words are fillers, their low bits hold their own byte address
0c000000 0c000004 0c000008 0c00000c
0c000010 0c000014
48110010
0c00001c 0c000020 0c000024 0c000028
0c00002c 0c000030 0c000034
48324008
0c00003c 0c000040 0c000044
50000008
0c00004c 0c000050 0c000054
51000008
0c00005c 0c000060 0c000064
58000000
0c00006c 0c000070 0c000074 0c000078
0c00007c
0c000080 0c000084 0c000088 0c00008c
0c000090 0c000094 0c000098 0c00009c
508000b0
0c0000a4 0c0000a8 0c0000ac

//--- flist.f
cpu_pkg.sv
pc_counter.sv
branch_control.sv
instr_rom.sv
if_id_reg.sv
fetch_unit.sv
tb_clock.sv
tb_fetch_unit.sv

//--- run.sh
#!/usr/bin/env bash
# builds the fetch unit testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert -f flist.f --top-module tb_fetch_unit -o sim_fetch_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/sim_fetch_unit)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

echo "$sim_output" | grep -qx "Simulation finished: PASS"
if [ $? -ne 0 ]; then
	exit 1
fi
exit 0
